// File: rtl/rv_pkg.sv
package rv_pkg;

	localparam int xlen = 32;

	typedef logic [4:0] reg_addr_t;

	// rv32i major opcodes
	localparam logic [6:0] op_r      = 7'b0110011;
	localparam logic [6:0] op_load   = 7'b0000011;
	localparam logic [6:0] op_alui   = 7'b0010011;
	localparam logic [6:0] op_jalr   = 7'b1100111;
	localparam logic [6:0] op_store  = 7'b0100011;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_lui    = 7'b0110111;
	localparam logic [6:0] op_auipc  = 7'b0010111;
	localparam logic [6:0] op_jal    = 7'b1101111;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_slt,
		alu_sltu,
		alu_sll,
		alu_srl,
		alu_sra,
		alu_pass_b
	} alu_op_e;

	typedef struct packed {
		logic    write_reg;
		logic    mem_read;
		logic    mem_write;
		// operand b from the immediate
		logic    alu_src_imm;
		// operand a from the pc
		logic    pc_rel;
		logic    branch;
		logic    jump;
		logic    jalr;
		logic    illegal;
		alu_op_e alu_op;
	} ctrl_t;

	typedef struct packed {
		logic            valid;
		logic [xlen-1:0] pc;
		reg_addr_t       rs1;
		reg_addr_t       rs2;
		reg_addr_t       rd;
		logic [2:0]      func3;
		logic [xlen-1:0] imm;
		ctrl_t           ctrl;
	} decoded_t;

	typedef struct packed {
		logic [xlen-1:0] pc;
		logic [xlen-1:0] next_pc;
		reg_addr_t       rd;
		logic            rd_we;
		logic [xlen-1:0] result;
		logic            mem_read;
		logic            mem_write;
		logic [xlen-1:0] mem_addr;
		logic [xlen-1:0] store_data;
		logic            illegal;
	} retire_t;

endpackage

// File: rtl/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   in_valid,
	input  logic [rv_pkg::xlen-1:0] in_instr,
	input  logic [rv_pkg::xlen-1:0] in_pc,
	output rv_pkg::decoded_t       dec
);
	import rv_pkg::*;

	logic [6:0] opcode;
	logic [2:0] func3;
	logic [6:0] func7;
	reg_addr_t  rs1;
	reg_addr_t  rs2;
	reg_addr_t  rd;
	ctrl_t      ctrl;
	logic [xlen-1:0] imm;

	assign opcode = in_instr[6:0];
	assign rd     = in_instr[11:7];
	assign func3  = in_instr[14:12];
	assign rs1    = in_instr[19:15];
	assign rs2    = in_instr[24:20];
	assign func7  = in_instr[31:25];

	// sub only exists in the register form
	function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt, input logic reg_form);
		case (f3)
			3'b000:  return (alt && reg_form) ? alu_sub : alu_add;
			3'b001:  return alu_sll;
			3'b010:  return alu_slt;
			3'b011:  return alu_sltu;
			3'b100:  return alu_xor;
			3'b101:  return alt ? alu_sra : alu_srl;
			3'b110:  return alu_or;
			default: return alu_and;
		endcase
	endfunction

	always_comb begin
		ctrl = '0;
		ctrl.alu_op = alu_add;
		imm = {{20{in_instr[31]}}, in_instr[31:20]};
		case (opcode)
			op_r: begin
				ctrl.write_reg = 1'b1;
				ctrl.alu_op = alu_sel(func3, func7[5], 1'b1);
			end
			op_alui: begin
				ctrl.write_reg = 1'b1;
				ctrl.alu_src_imm = 1'b1;
				ctrl.alu_op = alu_sel(func3, func7[5], 1'b0);
			end
			// load leaves as a request, rd untouched
			op_load: begin
				ctrl.mem_read = 1'b1;
				ctrl.alu_src_imm = 1'b1;
			end
			op_store: begin
				ctrl.mem_write = 1'b1;
				ctrl.alu_src_imm = 1'b1;
				imm = {{20{in_instr[31]}}, in_instr[31:25], in_instr[11:7]};
			end
			// alu forms pc + offset as the target
			op_branch: begin
				ctrl.branch = 1'b1;
				ctrl.pc_rel = 1'b1;
				ctrl.alu_src_imm = 1'b1;
				imm = {{19{in_instr[31]}}, in_instr[31], in_instr[7],
					in_instr[30:25], in_instr[11:8], 1'b0};
			end
			op_jal: begin
				ctrl.write_reg = 1'b1;
				ctrl.jump = 1'b1;
				ctrl.pc_rel = 1'b1;
				ctrl.alu_src_imm = 1'b1;
				imm = {{11{in_instr[31]}}, in_instr[31], in_instr[19:12],
					in_instr[20], in_instr[30:21], 1'b0};
			end
			op_jalr: begin
				ctrl.write_reg = 1'b1;
				ctrl.jump = 1'b1;
				ctrl.jalr = 1'b1;
				ctrl.alu_src_imm = 1'b1;
			end
			op_lui: begin
				ctrl.write_reg = 1'b1;
				ctrl.alu_src_imm = 1'b1;
				ctrl.alu_op = alu_pass_b;
				imm = {in_instr[31:12], 12'b0};
			end
			op_auipc: begin
				ctrl.write_reg = 1'b1;
				ctrl.pc_rel = 1'b1;
				ctrl.alu_src_imm = 1'b1;
				imm = {in_instr[31:12], 12'b0};
			end
			default: begin
				ctrl.illegal = 1'b1;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dec <= '0;
		end else begin
			dec.valid <= in_valid;
			dec.pc    <= in_pc;
			dec.rs1   <= rs1;
			dec.rs2   <= rs2;
			dec.rd    <= rd;
			dec.func3 <= func3;
			dec.imm   <= imm;
			dec.ctrl  <= ctrl;
		end
	end

endmodule

// File: rtl/reg_file.sv
`timescale 1ns/1ps

module reg_file (
	input  logic                    clk,
	input  logic                    rst_n,
	input  rv_pkg::reg_addr_t       ra1,
	input  rv_pkg::reg_addr_t       ra2,
	output logic [rv_pkg::xlen-1:0] rd1,
	output logic [rv_pkg::xlen-1:0] rd2,
	input  logic                    we,
	input  rv_pkg::reg_addr_t       wa,
	input  logic [rv_pkg::xlen-1:0] wd
);
	import rv_pkg::*;

	logic [xlen-1:0] regs [32];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && wa != '0) begin
			regs[wa] <= wd;
		end
	end

	// x0 reads as zero
	assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
	assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

// File: rtl/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
	input  logic             clk,
	input  logic             rst_n,
	input  rv_pkg::decoded_t dec,
	output rv_pkg::retire_t  ret
);
	import rv_pkg::*;

	logic [xlen-1:0] rs1_data;
	logic [xlen-1:0] rs2_data;
	logic [xlen-1:0] op_a;
	logic [xlen-1:0] op_b;
	logic [xlen-1:0] alu_y;
	logic [xlen-1:0] pc_plus4;
	logic [xlen-1:0] next_pc;
	logic [xlen-1:0] result;
	logic [4:0]      shamt;
	logic            taken;
	logic            rd_we;

	reg_file i_reg_file (
		.clk   (clk),
		.rst_n (rst_n),
		.ra1   (dec.rs1),
		.ra2   (dec.rs2),
		.rd1   (rs1_data),
		.rd2   (rs2_data),
		.we    (rd_we),
		.wa    (dec.rd),
		.wd    (result)
	);

	assign op_a  = dec.ctrl.pc_rel ? dec.pc : rs1_data;
	assign op_b  = dec.ctrl.alu_src_imm ? dec.imm : rs2_data;
	assign shamt = op_b[4:0];

	always_comb begin
		case (dec.ctrl.alu_op)
			alu_add:    alu_y = op_a + op_b;
			alu_sub:    alu_y = op_a - op_b;
			alu_and:    alu_y = op_a & op_b;
			alu_or:     alu_y = op_a | op_b;
			alu_xor:    alu_y = op_a ^ op_b;
			alu_slt:    alu_y = {31'b0, $signed(op_a) < $signed(op_b)};
			alu_sltu:   alu_y = {31'b0, op_a < op_b};
			alu_sll:    alu_y = op_a << shamt;
			alu_srl:    alu_y = op_a >> shamt;
			alu_sra:    alu_y = $unsigned($signed(op_a) >>> shamt);
			alu_pass_b: alu_y = op_b;
			default:    alu_y = op_a + op_b;
		endcase
	end

	// compare always on the register values
	always_comb begin
		case (dec.func3)
			3'b000:  taken = rs1_data == rs2_data;
			3'b001:  taken = rs1_data != rs2_data;
			3'b100:  taken = $signed(rs1_data) < $signed(rs2_data);
			3'b101:  taken = $signed(rs1_data) >= $signed(rs2_data);
			3'b110:  taken = rs1_data < rs2_data;
			3'b111:  taken = rs1_data >= rs2_data;
			default: taken = 1'b0;
		endcase
	end

	assign pc_plus4 = dec.pc + 32'd4;

	always_comb begin
		if (dec.ctrl.jump && dec.ctrl.jalr) begin
			next_pc = {alu_y[xlen-1:1], 1'b0};
		end else if (dec.ctrl.jump || (dec.ctrl.branch && taken)) begin
			next_pc = alu_y;
		end else begin
			next_pc = pc_plus4;
		end
	end

	// link value for jumps
	assign result = dec.ctrl.jump ? pc_plus4 : alu_y;
	assign rd_we  = dec.valid && dec.ctrl.write_reg && (dec.rd != '0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ret <= '0;
		end else begin
			ret.pc         <= dec.pc;
			ret.next_pc    <= next_pc;
			ret.rd         <= dec.rd;
			ret.rd_we      <= rd_we;
			ret.result     <= result;
			ret.mem_read   <= dec.ctrl.mem_read;
			ret.mem_write  <= dec.ctrl.mem_write;
			ret.mem_addr   <= alu_y;
			ret.store_data <= dec.ctrl.mem_write ? rs2_data : '0;
			ret.illegal    <= dec.ctrl.illegal;
		end
	end

endmodule

// File: rtl/retire_buffer.sv
`timescale 1ns/1ps

module retire_buffer #(
	parameter int depth   = 4,
	parameter int credits = 2
) (
	input  logic            clk,
	input  logic            rst_n,
	input  rv_pkg::retire_t in_rec,
	input  logic            in_valid,
	output logic            out_valid,
	output rv_pkg::retire_t out_rec,
	input  logic            out_credit,
	output logic            freed
);
	import rv_pkg::*;

	localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
	localparam int cnt_w = $clog2(depth + 1);
	localparam int crd_w = $clog2(credits + 1);

	retire_t mem [depth];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [cnt_w-1:0] count;
	logic [crd_w-1:0] credit_cnt;
	logic             pop;

	function automatic logic [ptr_w-1:0] bump(input logic [ptr_w-1:0] p);
		return (p == ptr_w'(depth - 1)) ? '0 : p + 1'b1;
	endfunction

	// send whenever a record waits and downstream has room
	assign pop       = (count != '0) && (credit_cnt != '0);
	assign out_valid = pop;
	assign out_rec   = mem[rd_ptr];
	assign freed     = pop;

	always_ff @(posedge clk) begin
		if (in_valid) begin
			mem[wr_ptr] <= in_rec;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credit_cnt <= crd_w'(credits);
		end else begin
			if (in_valid) begin
				wr_ptr <= bump(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= bump(rd_ptr);
			end
			case ({in_valid, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			case ({out_credit, pop})
				2'b10:   credit_cnt <= credit_cnt + 1'b1;
				2'b01:   credit_cnt <= credit_cnt - 1'b1;
				default: credit_cnt <= credit_cnt;
			endcase
		end
	end

endmodule

// File: rtl/rv_pipe_top.sv
`timescale 1ns/1ps

module rv_pipe_top #(
	parameter int retire_depth = 4,
	parameter int out_credits  = 2
) (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    in_valid,
	input  logic [rv_pkg::xlen-1:0] in_instr,
	input  logic [rv_pkg::xlen-1:0] in_pc,
	output logic                    in_credit,
	output logic                    out_valid,
	output rv_pkg::retire_t         out_rec,
	input  logic                    out_credit
);
	import rv_pkg::*;

	decoded_t dec;
	retire_t  ret;
	logic     ret_valid;

	decode_stage i_decode_stage (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_valid (in_valid),
		.in_instr (in_instr),
		.in_pc    (in_pc),
		.dec      (dec)
	);

	execute_stage i_execute_stage (
		.clk   (clk),
		.rst_n (rst_n),
		.dec   (dec),
		.ret   (ret)
	);

	// valid follows the record through execute
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ret_valid <= 1'b0;
		end else begin
			ret_valid <= dec.valid;
		end
	end

	retire_buffer #(
		.depth   (retire_depth),
		.credits (out_credits)
	) i_retire_buffer (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_rec     (ret),
		.in_valid   (ret_valid),
		.out_valid  (out_valid),
		.out_rec    (out_rec),
		.out_credit (out_credit),
		.freed      (in_credit)
	);

endmodule

// File: verification/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk
);
	// 8 ns period
	localparam int half_period = 4;

	initial begin
		clk = 1'b0;
	end

	always begin
		#half_period clk = ~clk;
	end

endmodule

// File: verification/rv_pipe_tb.sv
`timescale 1ns/1ps

module rv_pipe_tb;
	import rv_pkg::*;

	localparam int retire_depth   = 4;
	localparam int out_credits    = 2;
	localparam int n_instr        = 400;
	localparam int timeout_cycles = n_instr * 40 + 1000;

	// expected record plus which fields carry meaning
	typedef struct packed {
		retire_t rec;
		logic    chk_rd;
		logic    chk_mem;
		logic    chk_store;
	} expect_t;

	logic        clk;
	logic        rst_n;
	logic        in_valid;
	logic [31:0] in_instr;
	logic [31:0] in_pc;
	logic        in_credit;
	logic        out_valid;
	retire_t     out_rec;
	logic        out_credit;

	logic [31:0] rng_state;
	logic [31:0] model_regs [32];
	logic [31:0] model_pc;
	expect_t     expected [$];
	int          up_credits;
	int          owed;
	int          hold_cnt;
	int          sent;
	int          retired;

	tb_clock_gen i_clock_gen (
		.clk (clk)
	);

	rv_pipe_top #(
		.retire_depth (retire_depth),
		.out_credits  (out_credits)
	) i_rv_pipe_top (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_instr   (in_instr),
		.in_pc      (in_pc),
		.in_credit  (in_credit),
		.out_valid  (out_valid),
		.out_rec    (out_rec),
		.out_credit (out_credit)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_rand();
		rng_state = xorshift(rng_state);
		return rng_state;
	endfunction

	task automatic stop_on_error();
		$display("Checks failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic report_failure(input string what);
		$display("failure at %0t: %s", $time, what);
		stop_on_error();
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %0t %s got %08h expected %08h", $time, name, got, exp);
			stop_on_error();
		end
	endtask

	// alt selects sub or sra
	function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
			input logic [31:0] a, input logic [31:0] b);
		logic signed [31:0] sa;
		sa = a;
		case (f3)
			3'b000: return alt ? a - b : a + b;
			3'b001: return a << b[4:0];
			3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'b011: return (a < b) ? 32'd1 : 32'd0;
			3'b100: return a ^ b;
			3'b101: begin
				if (alt) begin
					return sa >>> b[4:0];
				end
				return a >> b[4:0];
			end
			3'b110: return a | b;
			default: return a & b;
		endcase
	endfunction

	// builds one random instruction and runs it on the model
	task automatic make_instr(output logic [31:0] instr);
		logic [31:0] r;
		logic [31:0] sel;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] opnd;
		logic [31:0] res;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [2:0]  f3;
		logic [6:0]  ill_op;
		logic        alt;
		logic        taken;
		logic        writes;
		expect_t     e;
		int          kind;
		int          k;

		rd   = 5'(next_rand() % 8);
		rs1  = 5'(next_rand() % 8);
		rs2  = 5'(next_rand() % 8);
		r    = next_rand();
		sel  = next_rand();
		kind = (next_rand() % 20 == 0) ? 9 : int'(next_rand() % 9);
		a    = model_regs[rs1];
		b    = model_regs[rs2];
		f3   = sel[2:0];
		alt  = 1'b0;
		res  = '0;
		writes = 1'b0;
		e = '0;
		e.rec.pc = model_pc;
		e.rec.next_pc = model_pc + 32'd4;
		e.rec.rd = rd;
		case (kind)
			0: begin
				alt = (f3 == 3'b000 || f3 == 3'b101) ? sel[3] : 1'b0;
				instr = {1'b0, alt, 5'b0, rs2, rs1, f3, rd, op_r};
				res = alu_ref(f3, alt, a, b);
				writes = 1'b1;
			end
			1: begin
				if (f3 == 3'b001 || f3 == 3'b101) begin
					alt = (f3 == 3'b101) ? sel[3] : 1'b0;
					opnd = {27'b0, r[4:0]};
					instr = {1'b0, alt, 5'b0, r[4:0], rs1, f3, rd, op_alui};
				end else begin
					opnd = {{20{r[11]}}, r[11:0]};
					instr = {opnd[11:0], rs1, f3, rd, op_alui};
				end
				res = alu_ref(f3, alt, a, opnd);
				writes = 1'b1;
			end
			2: begin
				f3 = 3'(sel % 3);
				opnd = {{20{r[11]}}, r[11:0]};
				instr = {opnd[11:0], rs1, f3, rd, op_load};
				e.rec.mem_read = 1'b1;
				e.rec.mem_addr = a + opnd;
				e.chk_mem = 1'b1;
			end
			3: begin
				f3 = 3'(sel % 3);
				opnd = {{20{r[11]}}, r[11:0]};
				instr = {opnd[11:5], rs2, rs1, f3, opnd[4:0], op_store};
				e.rec.mem_write = 1'b1;
				e.rec.mem_addr = a + opnd;
				e.rec.store_data = b;
				e.chk_mem = 1'b1;
				e.chk_store = 1'b1;
			end
			4: begin
				k = int'(sel % 6);
				f3 = (k < 2) ? 3'(k) : 3'(k + 2);
				opnd = {{19{r[12]}}, r[12:1], 1'b0};
				instr = {opnd[12], opnd[10:5], rs2, rs1, f3, opnd[4:1], opnd[11], op_branch};
				case (f3)
					3'b000: taken = a == b;
					3'b001: taken = a != b;
					3'b100: taken = $signed(a) < $signed(b);
					3'b101: taken = $signed(a) >= $signed(b);
					3'b110: taken = a < b;
					default: taken = a >= b;
				endcase
				if (taken) begin
					e.rec.next_pc = model_pc + opnd;
				end
			end
			5: begin
				opnd = {{11{r[20]}}, r[20:1], 1'b0};
				instr = {opnd[20], opnd[10:1], opnd[11], opnd[19:12], rd, op_jal};
				e.rec.next_pc = model_pc + opnd;
				res = model_pc + 32'd4;
				writes = 1'b1;
			end
			6: begin
				opnd = {{20{r[11]}}, r[11:0]};
				instr = {opnd[11:0], rs1, 3'b000, rd, op_jalr};
				e.rec.next_pc = (a + opnd) & ~32'd1;
				res = model_pc + 32'd4;
				writes = 1'b1;
			end
			7: begin
				opnd = {r[31:12], 12'b0};
				instr = {opnd[31:12], rd, op_lui};
				res = opnd;
				writes = 1'b1;
			end
			8: begin
				opnd = {r[31:12], 12'b0};
				instr = {opnd[31:12], rd, op_auipc};
				res = model_pc + opnd;
				writes = 1'b1;
			end
			default: begin
				case (sel[4:3])
					2'd0: ill_op = 7'b0001111;
					2'd1: ill_op = 7'b1110011;
					2'd2: ill_op = 7'b0101111;
					default: ill_op = 7'b1010011;
				endcase
				instr = {r[31:7], ill_op};
				e.rec.illegal = 1'b1;
			end
		endcase
		e.rec.rd_we = writes && (rd != 5'd0);
		e.rec.result = res;
		e.chk_rd = writes;
		// x0 never changes
		if (writes && rd != 5'd0) begin
			model_regs[rd] = res;
		end
		model_pc = e.rec.next_pc;
		expected.push_back(e);
	endtask

	task automatic check_record(input retire_t got);
		expect_t e;
		if (expected.size() == 0) begin
			report_failure("a record retired with no instruction outstanding");
		end else begin
			e = expected.pop_front();
			check_value("out_rec.pc", got.pc, e.rec.pc);
			check_value("out_rec.next_pc", got.next_pc, e.rec.next_pc);
			check_value("out_rec.illegal", 32'(got.illegal), 32'(e.rec.illegal));
			check_value("out_rec.rd_we", 32'(got.rd_we), 32'(e.rec.rd_we));
			check_value("out_rec.mem_read", 32'(got.mem_read), 32'(e.rec.mem_read));
			check_value("out_rec.mem_write", 32'(got.mem_write), 32'(e.rec.mem_write));
			if (e.chk_rd) begin
				check_value("out_rec.rd", 32'(got.rd), 32'(e.rec.rd));
				check_value("out_rec.result", got.result, e.rec.result);
			end
			if (e.chk_mem) begin
				check_value("out_rec.mem_addr", got.mem_addr, e.rec.mem_addr);
			end
			if (e.chk_store) begin
				check_value("out_rec.store_data", got.store_data, e.rec.store_data);
			end
		end
	endtask

	task automatic drive_upstream();
		logic [31:0] instr;
		if (up_credits > 0 && sent < n_instr && next_rand() % 8 != 0) begin
			in_pc = model_pc;
			make_instr(instr);
			in_instr = instr;
			in_valid = 1'b1;
			up_credits--;
			sent++;
		end else begin
			in_valid = 1'b0;
			in_instr = '0;
		end
	endtask

	// credits go back at random and are sometimes held back in bursts
	task automatic drive_downstream();
		out_credit = 1'b0;
		if (hold_cnt > 0) begin
			hold_cnt--;
		end else if (next_rand() % 16 == 0) begin
			hold_cnt = int'(8 + next_rand() % 24);
		end else if (owed > 0 && next_rand() % 4 != 0) begin
			out_credit = 1'b1;
			owed--;
		end
	endtask

	// outputs sampled mid cycle
	always @(negedge clk) begin
		if (rst_n) begin
			if (in_credit) begin
				up_credits++;
				if (up_credits > retire_depth) begin
					report_failure("more credits came back upstream than were spent");
				end
			end
			if (out_valid) begin
				check_record(out_rec);
				retired++;
				owed++;
				if (owed > out_credits) begin
					report_failure("a record was sent without an output credit");
				end
			end
			if (sent - retired > out_credits + retire_depth) begin
				report_failure("too many records outstanding in the pipeline");
			end
		end
	end

	initial begin
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_instr = '0;
		in_pc = '0;
		out_credit = 1'b0;
		rng_state = 32'hb853_19be;
		model_pc = 32'h0000_1000;
		up_credits = retire_depth;
		owed = 0;
		hold_cnt = 0;
		sent = 0;
		retired = 0;
		for (int i = 0; i < 32; i++) begin
			model_regs[i] = '0;
		end
		repeat (16) @(posedge clk);
		#1;
		rst_n = 1'b1;
		while (retired < n_instr) begin
			@(posedge clk);
			#1;
			drive_upstream();
			drive_downstream();
		end
		@(posedge clk);
		#1;
		in_valid = 1'b0;
		out_credit = 1'b0;
		repeat (4) @(posedge clk);
		check_value("upstream credits", up_credits, retire_depth);
		$display("All checks passed");
		$finish;
	end

	initial begin
		repeat (timeout_cycles) @(posedge clk);
		$display("watchdog expired after %0d cycles with %0d of %0d records retired",
			timeout_cycles, retired, n_instr);
		$display("Checks failed");
		$fatal(1, "timeout");
	end

endmodule

// File: rv_pipe.f
rtl/rv_pkg.sv
rtl/decode_stage.sv
rtl/reg_file.sv
rtl/execute_stage.sv
rtl/retire_buffer.sv
rtl/rv_pipe_top.sv
verification/tb_clock_gen.sv
verification/rv_pipe_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= rv_pipe_tb
FILELIST  ?= rv_pipe.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All checks passed
VFLAGS    ?= --binary --timing -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
